/* common/ahb_apb_pkg.sv */
// shared widths, AMBA codes, protection bits and GPIO offsets; imported by every bridge and GPIO module
`default_nettype none

package ahb_apb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int haddr_size = 32;  // AHB address
  localparam int hdata_size = 32;  // AHB data, word max
  localparam int paddr_size = 10;  // APB address
  localparam int pdata_size = 8;   // APB data, also GPIO pin count

  // flops per crossing
  localparam int sync_depth = 3;

  ////////////////////////////////////////////////////////////////////////////
  // AMBA codes
  ////////////////////////////////////////////////////////////////////////////

  // htrans
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_busy   = 2'b01;
  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  // hsize, nothing wider than the data bus
  localparam logic [2:0] hsize_byte  = 3'b000;
  localparam logic [2:0] hsize_hword = 3'b001;
  localparam logic [2:0] hsize_word  = 3'b010;

  // hresp, AHB-Lite only has two
  localparam logic hresp_okay  = 1'b0;
  localparam logic hresp_error = 1'b1;

  // protection bit positions
  localparam int hprot_data_bit  = 0;  // set = data access
  localparam int hprot_priv_bit  = 1;  // set = privileged
  localparam int pprot_priv_bit  = 0;
  localparam int pprot_instr_bit = 2;

  ////////////////////////////////////////////////////////////////////////////
  // GPIO register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [paddr_size-1:0] gpio_out_ofs = 'd0;  // output value
  localparam logic [paddr_size-1:0] gpio_oe_ofs  = 'd1;  // output enable, privileged write
  localparam logic [paddr_size-1:0] gpio_in_ofs  = 'd2;  // synced pins, read only

  ////////////////////////////////////////////////////////////////////////////
  // bridge state encodings
  ////////////////////////////////////////////////////////////////////////////

  // AHB side, HCLK domain
  localparam logic [1:0] ahb_st_idle  = 2'd0;
  localparam logic [1:0] ahb_st_wait  = 2'd1;  // waiting on APB ack
  localparam logic [1:0] ahb_st_error = 2'd2;  // second error cycle

  // APB side, pclk domain
  localparam logic [1:0] apb_st_idle   = 2'd0;
  localparam logic [1:0] apb_st_setup  = 2'd1;
  localparam logic [1:0] apb_st_access = 2'd2;

endpackage

`default_nettype wire

/* hw/bridge/ahb_apb_bridge.sv */
// AHB-Lite slave to APB master bridge across HCLK and pclk; splits each AHB transfer into byte beats
`default_nettype none
`timescale 1ns/1ps

module ahb_apb_bridge
  import ahb_apb_pkg::*;
(
  // AHB-Lite slave
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  hsel,
  input  logic [haddr_size-1:0] haddr,
  input  logic [hdata_size-1:0] hwdata,
  input  logic                  hwrite,
  input  logic [2:0]            hsize,
  input  logic [2:0]            hburst,     // bursts run as singles, ignored
  input  logic [3:0]            hprot,
  input  logic [1:0]            htrans,
  input  logic                  hmastlock,  // no locked sequences, ignored
  input  logic                  hready,
  output logic [hdata_size-1:0] hrdata,
  output logic                  hreadyout,
  output logic                  hresp,

  // APB master
  input  logic                  pclk,
  input  logic                  presetn,
  output logic                  psel,
  output logic                  penable,
  output logic [2:0]            pprot,
  output logic                  pwrite,
  output logic                  pstrb,
  output logic [paddr_size-1:0] paddr,
  output logic [pdata_size-1:0] pwdata,
  input  logic [pdata_size-1:0] prdata,
  input  logic                  pready,
  input  logic                  pslverr
);

  // HCLK domain
  logic                  ahb_accept;  // valid address phase seen
  logic [1:0]            ahb_state;
  logic                  ahb_req;     // data phase strobe, starts crossing
  logic                  ahb_ack;     // transfer done strobe
  logic [haddr_size-1:0] haddr_q;
  logic [hdata_size-1:0] hwdata_q;
  logic                  hwrite_q;
  logic [2:0]            hsize_q;
  logic [3:0]            hprot_q;

  // pclk domain
  logic                  apb_req;
  logic                  apb_ack;
  logic [1:0]            apb_state;
  logic [1:0]            beat_cnt;    // current beat
  logic [1:0]            beat_last;   // 0, 1 or 3 from hsize
  logic [1:0]            lane;        // byte lane of current beat
  logic [1:0]            lane_nxt;
  logic [2:0]            pprot_nxt;
  logic [hdata_size-1:0] rdata_q;     // assembled read word
  logic                  err_q;       // last beat's pslverr

  ////////////////////////////////////////////////////////////////////////////
  // AHB side
  ////////////////////////////////////////////////////////////////////////////

  assign ahb_accept = hsel & hready & ((htrans == htrans_nonseq) | (htrans == htrans_seq));

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ahb_state <= ahb_st_idle;
      hreadyout <= 1'b1;
      hresp     <= hresp_okay;
      ahb_req   <= 1'b0;
    end else begin
      ahb_req <= 1'b0;  // single cycle
      case (ahb_state)
        ahb_st_idle: begin
          hreadyout <= 1'b1;
          hresp     <= hresp_okay;  // also ends the 2nd error cycle
          if (ahb_accept) begin
            ahb_state <= ahb_st_wait;
            hreadyout <= 1'b0;      // stall data phase
            ahb_req   <= 1'b1;      // toggles with hwdata capture
          end
        end
        ahb_st_wait: begin
          if (ahb_ack) begin
            if (err_q) begin
              // first error cycle, hreadyout stays low
              ahb_state <= ahb_st_error;
              hresp     <= hresp_error;
            end else begin
              ahb_state <= ahb_st_idle;
              hreadyout <= 1'b1;
            end
          end
        end
        ahb_st_error: begin
          ahb_state <= ahb_st_idle;
          hreadyout <= 1'b1;        // hresp still error
        end
        default: begin
          ahb_state <= ahb_st_idle;
        end
      endcase
    end
  end

  // transfer payload, held until ack
  always_ff @(posedge HCLK) begin
    if (ahb_accept && ahb_state == ahb_st_idle) begin
      haddr_q  <= haddr;
      hwrite_q <= hwrite;
      hsize_q  <= hsize;
      hprot_q  <= hprot;
    end
    if (ahb_req) begin
      hwdata_q <= hwdata;  // data phase
    end
    if (ahb_ack) begin
      hrdata <= rdata_q;   // stable in pclk domain since ack
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // crossings
  ////////////////////////////////////////////////////////////////////////////

  cdc_pulse_sync u_req_sync (
    .src_clk   (HCLK),
    .src_rst_n (HRESETn),
    .src_pulse (ahb_req),
    .dst_clk   (pclk),
    .dst_rst_n (presetn),
    .dst_pulse (apb_req)
  );

  cdc_pulse_sync u_ack_sync (
    .src_clk   (pclk),
    .src_rst_n (presetn),
    .src_pulse (apb_ack),
    .dst_clk   (HCLK),
    .dst_rst_n (HRESETn),
    .dst_pulse (ahb_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // APB side
  ////////////////////////////////////////////////////////////////////////////

  // one beat per byte
  always_comb begin
    case (hsize_q)
      hsize_byte:  beat_last = 2'd0;
      hsize_hword: beat_last = 2'd1;
      default:     beat_last = 2'd3;
    endcase
  end

  assign lane_nxt = lane + 2'd1;  // wraps within the word

  always_comb begin
    pprot_nxt                  = 3'b000;  // secure, middle bit zero
    pprot_nxt[pprot_priv_bit]  = hprot_q[hprot_priv_bit];
    pprot_nxt[pprot_instr_bit] = ~hprot_q[hprot_data_bit];
  end

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      apb_state <= apb_st_idle;
      apb_ack   <= 1'b0;
      psel      <= 1'b0;
      penable   <= 1'b0;
      pprot     <= 3'b000;
      pwrite    <= 1'b0;
      pstrb     <= 1'b0;
      paddr     <= '0;
      pwdata    <= '0;
      beat_cnt  <= 2'd0;
      lane      <= 2'd0;
      err_q     <= 1'b0;
    end else begin
      apb_ack <= 1'b0;
      case (apb_state)
        apb_st_idle: begin
          if (apb_req) begin
            apb_state <= apb_st_setup;
            psel      <= 1'b1;
            penable   <= 1'b0;
            pprot     <= pprot_nxt;
            pwrite    <= hwrite_q;
            pstrb     <= hwrite_q;  // single byte lane, on for writes
            paddr     <= haddr_q[paddr_size-1:0];
            pwdata    <= hwdata_q[pdata_size*haddr_q[1:0] +: pdata_size];
            lane      <= haddr_q[1:0];
            beat_cnt  <= 2'd0;
            err_q     <= 1'b0;
          end
        end
        apb_st_setup: begin
          apb_state <= apb_st_access;
          penable   <= 1'b1;
        end
        apb_st_access: begin
          if (pready) begin
            penable <= 1'b0;
            err_q   <= pslverr;
            if (pslverr || beat_cnt == beat_last) begin
              // done, later beats dropped on error
              apb_state <= apb_st_idle;
              psel      <= 1'b0;
              pwrite    <= 1'b0;
              pstrb     <= 1'b0;
              apb_ack   <= 1'b1;
            end else begin
              apb_state <= apb_st_setup;  // next beat, psel stays
              paddr     <= paddr + 1'b1;
              lane      <= lane_nxt;
              beat_cnt  <= beat_cnt + 2'd1;
              pwdata    <= hwdata_q[pdata_size*lane_nxt +: pdata_size];
            end
          end
        end
        default: begin
          apb_state <= apb_st_idle;
        end
      endcase
    end
  end

  // read lanes, unused lanes left zero
  always_ff @(posedge pclk) begin
    if (apb_state == apb_st_idle && apb_req) begin
      rdata_q <= '0;
    end else if (apb_state == apb_st_access && pready && !pwrite) begin
      rdata_q[pdata_size*lane +: pdata_size] <= prdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_hsize_max: assert property (
    @(posedge HCLK) disable iff (!HRESETn) ahb_accept |-> (hsize <= hsize_word));

  a_penable_psel: assert property (
    @(posedge pclk) disable iff (!presetn) penable |-> psel);

  // address held from setup until the slave completes
  a_paddr_stable: assert property (
    @(posedge pclk) disable iff (!presetn)
    (psel && !(penable && pready)) |=> $stable(paddr));

endmodule

`default_nettype wire

/* hw/bridge/cdc_pulse_sync.sv */
// single-pulse crossing via a source toggle and a destination flop chain; one per direction in the bridge
`default_nettype none
`timescale 1ns/1ps

module cdc_pulse_sync
  import ahb_apb_pkg::*;
(
  input  logic src_clk,
  input  logic src_rst_n,
  input  logic src_pulse,
  input  logic dst_clk,
  input  logic dst_rst_n,
  output logic dst_pulse
);

  logic                  src_toggle;  // flips once per pulse
  logic [sync_depth-1:0] dst_sync;    // [0] is the metastable stage

  // source side
  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      src_toggle <= 1'b0;
    end else if (src_pulse) begin
      src_toggle <= ~src_toggle;
    end
  end

  // destination side, shift toggle in
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      dst_sync <= '0;
    end else begin
      dst_sync <= {dst_sync[sync_depth-2:0], src_toggle};
    end
  end

  // edge of the synced toggle, one dst clock wide
  assign dst_pulse = dst_sync[sync_depth-1] ^ dst_sync[sync_depth-2];

  // back-to-back pulses would cancel in the toggle
  a_src_pulse_single: assert property (
    @(posedge src_clk) disable iff (!src_rst_n) src_pulse |=> !src_pulse);

endmodule

`default_nettype wire

/* hw/gpio/gpio_apb_regs.sv */
// 8-bit APB GPIO slave with output, privileged enable and synced input registers; one wait state per access
`default_nettype none
`timescale 1ns/1ps

module gpio_apb_regs
  import ahb_apb_pkg::*;
(
  input  logic                  pclk,
  input  logic                  presetn,
  input  logic                  psel,
  input  logic                  penable,
  input  logic [2:0]            pprot,
  input  logic                  pwrite,
  input  logic                  pstrb,
  input  logic [paddr_size-1:0] paddr,
  input  logic [pdata_size-1:0] pwdata,
  output logic [pdata_size-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic [pdata_size-1:0] gpio_in,
  output logic [pdata_size-1:0] gpio_out,
  output logic [pdata_size-1:0] gpio_oe
);

  logic                  access;   // access phase
  logic                  acc_err;  // decoded error
  logic                  wr_en;
  logic [pdata_size-1:0] rd_mux;
  logic [pdata_size-1:0] in_meta;  // first pin stage
  logic [pdata_size-1:0] in_sync;  // readable pins

  assign access = psel & penable;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    acc_err = 1'b0;
    if (paddr > gpio_in_ofs) begin
      acc_err = 1'b1;  // unmapped
    end else if (pwrite && paddr == gpio_in_ofs) begin
      acc_err = 1'b1;  // read only
    end else if (pwrite && paddr == gpio_oe_ofs && !pprot[pprot_priv_bit]) begin
      acc_err = 1'b1;  // user write to enables
    end
  end

  always_comb begin
    case (paddr)
      gpio_out_ofs: rd_mux = gpio_out;
      gpio_oe_ofs:  rd_mux = gpio_oe;
      gpio_in_ofs:  rd_mux = in_sync;
      default:      rd_mux = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // wait state and response
  ////////////////////////////////////////////////////////////////////////////

  // pready one pclk after penable rises
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= access & ~pready;
      pslverr <= access & ~pready & acc_err;
    end
  end

  // read data captured in the wait state, zero on error
  always_ff @(posedge pclk) begin
    if (access && !pready) begin
      prdata <= (pwrite || acc_err) ? '0 : rd_mux;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  // lands on the completing edge
  assign wr_en = access & pready & pwrite & pstrb & ~acc_err;

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else if (wr_en) begin
      case (paddr)
        gpio_out_ofs: gpio_out <= pwdata;
        gpio_oe_ofs:  gpio_oe  <= pwdata;
        default:      gpio_out <= gpio_out;  // gpio_in, blocked by acc_err
      endcase
    end
  end

  // pin synchronizer, two flops
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in;
      in_sync <= in_meta;
    end
  end

  // one lane per beat, strobe follows write
  a_pstrb_pwrite: assert property (
    @(posedge pclk) disable iff (!presetn) access |-> (pstrb == pwrite));

endmodule

`default_nettype wire

/* hw/gpio_bridge_top.sv */
// top level joining the AHB to APB bridge and the GPIO block; exposes the AHB port, APB clock and pins
`default_nettype none
`timescale 1ns/1ps

module gpio_bridge_top
  import ahb_apb_pkg::*;
(
  // AHB-Lite
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  hsel,
  input  logic [haddr_size-1:0] haddr,
  input  logic [hdata_size-1:0] hwdata,
  input  logic                  hwrite,
  input  logic [2:0]            hsize,
  input  logic [2:0]            hburst,
  input  logic [3:0]            hprot,
  input  logic [1:0]            htrans,
  input  logic                  hmastlock,
  input  logic                  hready,
  output logic [hdata_size-1:0] hrdata,
  output logic                  hreadyout,
  output logic                  hresp,

  // peripheral clock
  input  logic                  pclk,
  input  logic                  presetn,

  // pins
  input  logic [pdata_size-1:0] gpio_in,
  output logic [pdata_size-1:0] gpio_out,
  output logic [pdata_size-1:0] gpio_oe
);

  // APB link
  logic                  psel;
  logic                  penable;
  logic [2:0]            pprot;
  logic                  pwrite;
  logic                  pstrb;
  logic [paddr_size-1:0] paddr;
  logic [pdata_size-1:0] pwdata;
  logic [pdata_size-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  ahb_apb_bridge u_bridge (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwdata    (hwdata),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hburst    (hburst),
    .hprot     (hprot),
    .htrans    (htrans),
    .hmastlock (hmastlock),
    .hready    (hready),
    .hrdata    (hrdata),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .pclk      (pclk),
    .presetn   (presetn),
    .psel      (psel),
    .penable   (penable),
    .pprot     (pprot),
    .pwrite    (pwrite),
    .pstrb     (pstrb),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  gpio_apb_regs u_gpio (
    .pclk     (pclk),
    .presetn  (presetn),
    .psel     (psel),
    .penable  (penable),
    .pprot    (pprot),
    .pwrite   (pwrite),
    .pstrb    (pstrb),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile the GPIO bridge testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_gpio_bridge -Mdir obj_dir -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation reported errors"
  exit 1
fi
exit "$status"

/* tb.f */
+incdir+tests
common/ahb_apb_pkg.sv
hw/bridge/cdc_pulse_sync.sv
hw/bridge/ahb_apb_bridge.sv
hw/gpio/gpio_apb_regs.sv
hw/gpio_bridge_top.sv
tests/tb_gpio_bridge.sv

/* tests/gpio_bridge_tests.svh */
// directed tests and reference model of GPIO registers and byte lanes; included in the testbench top
`ifndef gpio_bridge_tests_svh
`define gpio_bridge_tests_svh

  // reference model state
  logic [pdata_size-1:0] model_out  = '0;
  logic [pdata_size-1:0] model_oe   = '0;
  logic [pdata_size-1:0] model_pins = '0;  // last value driven on gpio_in

  localparam logic [3:0] prot_priv = 4'b0011;  // privileged data
  localparam logic [3:0] prot_user = 4'b0001;  // user data

  // walks the beats and stops at the first error beat
  task automatic predict_xfer(input logic [haddr_size-1:0] addr, input logic [2:0] size,
                              input logic wr, input logic [3:0] prot,
                              input logic [hdata_size-1:0] wdata,
                              output logic [hdata_size-1:0] rword, output logic err);
    int                    nbeats;
    int                    k;
    logic [paddr_size-1:0] ofs;
    logic [1:0]            lane;
    case (size)
      hsize_byte:  nbeats = 1;
      hsize_hword: nbeats = 2;
      default:     nbeats = 4;
    endcase
    rword = '0;
    err   = 1'b0;
    for (k = 0; k < nbeats && !err; k++) begin
      ofs  = addr[paddr_size-1:0] + k[paddr_size-1:0];
      lane = addr[1:0] + k[1:0];  // wraps in the word
      if (ofs > gpio_in_ofs) begin
        err = 1'b1;  // unmapped
      end else if (wr && ofs == gpio_in_ofs) begin
        err = 1'b1;  // pins are read only
      end else if (wr && ofs == gpio_oe_ofs && !prot[hprot_priv_bit]) begin
        err = 1'b1;
      end else if (wr && ofs == gpio_out_ofs) begin
        model_out = wdata[pdata_size*lane +: pdata_size];
      end else if (wr) begin
        model_oe = wdata[pdata_size*lane +: pdata_size];
      end else if (ofs == gpio_out_ofs) begin
        rword[pdata_size*lane +: pdata_size] = model_out;
      end else if (ofs == gpio_oe_ofs) begin
        rword[pdata_size*lane +: pdata_size] = model_oe;
      end else begin
        rword[pdata_size*lane +: pdata_size] = model_pins;
      end
    end
  endtask

  task automatic xfer_and_compare(input logic [haddr_size-1:0] addr, input logic [2:0] size,
                                  input logic wr, input logic [3:0] prot,
                                  input logic [hdata_size-1:0] wdata);
    logic [hdata_size-1:0] exp_word;
    logic [hdata_size-1:0] got_word;
    logic                  exp_err;
    logic                  got_resp;
    predict_xfer(addr, size, wr, prot, wdata, exp_word, exp_err);
    ahb_xfer(addr, size, wr, prot, wdata, got_word, got_resp);
    check_hresp("hresp", exp_err ? hresp_error : hresp_okay, got_resp);
    if (!wr) begin
      check_hrdata("hrdata", exp_word, got_word);  // errored lanes read zero
    end
    check_pins("gpio_out", model_out, gpio_out);
    check_pins("gpio_oe", model_oe, gpio_oe);
  endtask

  task automatic log_test_result(input string name, input int errs_before);
    tests_run++;
    $display("test %-24s %s", name, (errors == errs_before) ? "passed" : "FAILED");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic verify_reset_state();
    int errs_before;
    errs_before = errors;
    @(negedge HCLK);
    check_hresp("hreadyout", 1'b1, hreadyout);
    check_hresp("hresp", hresp_okay, hresp);
    check_pins("gpio_out", '0, gpio_out);
    check_pins("gpio_oe", '0, gpio_oe);
    log_test_result("reset state", errs_before);
  endtask

  task automatic byte_write_read();
    int          errs_before;
    int          i;
    logic [31:0] val;
    errs_before = errors;
    for (i = 0; i < 3; i++) begin
      take_bits(32, val);  // other lanes random and ignored
      xfer_and_compare(32'h0, hsize_byte, 1'b1, prot_user, val);
    end
    xfer_and_compare(32'h0, hsize_byte, 1'b0, prot_user, '0);
    xfer_and_compare(32'h400, hsize_byte, 1'b0, prot_user, '0);  // aliases offset 0
    xfer_and_compare(32'h4, hsize_byte, 1'b0, prot_user, '0);    // unmapped offset 4
    log_test_result("byte write and read", errs_before);
  endtask

  task automatic word_write_pin_readback();
    int          errs_before;
    logic [31:0] val;
    errs_before = errors;
    take_bits(32, val);
    xfer_and_compare(32'h0, hsize_word, 1'b1, prot_priv, val);  // beat 2 hits gpio_in
    take_bits(pdata_size, val);
    @(posedge HCLK);
    gpio_in    <= val[pdata_size-1:0];
    model_pins  = val[pdata_size-1:0];
    repeat (10) @(posedge HCLK);  // pin synchronizer settles
    xfer_and_compare(32'h2, hsize_hword, 1'b0, prot_user, '0);  // 2nd beat at offset 3
    xfer_and_compare(32'h2, hsize_byte, 1'b0, prot_user, '0);
    log_test_result("word write, pin readback", errs_before);
  endtask

  task automatic protection_errors();
    int          errs_before;
    logic [31:0] val;
    errs_before = errors;
    take_bits(32, val);
    xfer_and_compare(32'h1, hsize_byte, 1'b1, prot_user, val);  // oe needs privilege
    xfer_and_compare(32'h5, hsize_byte, 1'b0, prot_user, '0);
    take_bits(32, val);
    xfer_and_compare(32'h1, hsize_byte, 1'b1, prot_priv, val);
    xfer_and_compare(32'h1, hsize_byte, 1'b0, prot_user, '0);   // user may read oe
    log_test_result("protection and unmapped", errs_before);
  endtask

  task automatic ignore_non_transfers();
    int errs_before;
    errs_before = errors;
    @(posedge HCLK);
    hsel   <= 1'b1;
    hwrite <= 1'b1;
    haddr  <= 32'h0;
    hsize  <= hsize_byte;
    htrans <= htrans_idle;
    @(posedge HCLK);
    hwdata <= {4{~model_out}};  // would change gpio_out if taken
    htrans <= htrans_busy;
    @(negedge HCLK);
    check_hresp("hreadyout", 1'b1, hreadyout);
    @(posedge HCLK);
    hsel   <= 1'b0;            // deselected nonseq
    htrans <= htrans_nonseq;
    @(negedge HCLK);
    check_hresp("hreadyout", 1'b1, hreadyout);
    @(posedge HCLK);
    htrans <= htrans_idle;
    @(negedge HCLK);
    check_hresp("hreadyout", 1'b1, hreadyout);  // deselected nonseq not taken
    repeat (40) @(negedge HCLK);  // longer than any real transfer
    check_hresp("hreadyout", 1'b1, hreadyout);
    check_pins("gpio_out", model_out, gpio_out);
    xfer_and_compare(32'h0, hsize_byte, 1'b0, prot_user, '0);
    log_test_result("non-transfers ignored", errs_before);
  endtask

`endif

/* tests/tb_gpio_bridge.sv */
// testbench top for the GPIO bridge; drives the AHB port and pins and runs the directed tests
`default_nettype none
`timescale 1ns/1ps

module tb_gpio_bridge
  import ahb_apb_pkg::*;
();

  localparam int num_tests   = 5;
  localparam int watchdog_ns = num_tests * 2000;
  localparam int xfer_limit  = 200;  // HCLK cycles before a transfer counts as hung

  logic                  HCLK = 1'b0;
  logic                  pclk = 1'b0;
  logic                  HRESETn;
  logic                  presetn;
  logic                  hsel;
  logic [haddr_size-1:0] haddr;
  logic [hdata_size-1:0] hwdata;
  logic                  hwrite;
  logic [2:0]            hsize;
  logic [2:0]            hburst;
  logic [3:0]            hprot;
  logic [1:0]            htrans;
  logic                  hmastlock;
  logic                  hready;
  logic [hdata_size-1:0] hrdata;
  logic                  hreadyout;
  logic                  hresp;
  logic [pdata_size-1:0] gpio_in;
  logic [pdata_size-1:0] gpio_out;
  logic [pdata_size-1:0] gpio_oe;

  int          errors     = 0;
  int          checks     = 0;
  int          tests_run  = 0;
  logic [31:0] lfsr_state = 32'h8d1f_8549;

  always #5 HCLK = ~HCLK;  // 100 MHz
  always #7 pclk = ~pclk;  // slower APB side, unrelated phase

  gpio_bridge_top u_gpio_bridge_top (
    .HCLK (HCLK), .HRESETn (HRESETn), .hsel (hsel), .haddr (haddr), .hwdata (hwdata),
    .hwrite (hwrite), .hsize (hsize), .hburst (hburst), .hprot (hprot), .htrans (htrans),
    .hmastlock (hmastlock), .hready (hready), .hrdata (hrdata), .hreadyout (hreadyout),
    .hresp (hresp), .pclk (pclk), .presetn (presetn), .gpio_in (gpio_in),
    .gpio_out (gpio_out), .gpio_oe (gpio_oe)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random source
  ////////////////////////////////////////////////////////////////////////////

  // right-shifting Galois form, taps x^32 x^22 x^2 x^1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val[i]     = lfsr_state[0];
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare and report
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_hrdata(input string name, input logic [hdata_size-1:0] exp,
                              input logic [hdata_size-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_hresp(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("mismatch at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_pins(input string name, input logic [pdata_size-1:0] exp,
                            input logic [pdata_size-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("mismatch at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AHB master
  ////////////////////////////////////////////////////////////////////////////

  // one single transfer, responses sampled on the falling edge
  task automatic ahb_xfer(input logic [haddr_size-1:0] addr, input logic [2:0] size,
                          input logic wr, input logic [3:0] prot,
                          input logic [hdata_size-1:0] wdata,
                          output logic [hdata_size-1:0] rdata, output logic resp);
    int   waited;
    logic first_err;  // saw error with hreadyout low
    logic done;
    @(posedge HCLK);
    hsel   <= 1'b1;
    haddr  <= addr;
    hwrite <= wr;
    hsize  <= size;
    hprot  <= prot;
    htrans <= htrans_nonseq;
    @(posedge HCLK);  // address phase taken here
    hsel   <= 1'b0;
    htrans <= htrans_idle;
    hwdata <= wdata;  // data phase
    waited    = 0;
    first_err = 1'b0;
    done      = 1'b0;
    resp      = hresp_okay;
    rdata     = '0;
    while (!done && waited < xfer_limit) begin
      @(negedge HCLK);
      waited++;
      if (!hreadyout && hresp == hresp_error) begin
        first_err = 1'b1;
      end else if (hreadyout) begin
        done  = 1'b1;
        resp  = hresp;
        rdata = hrdata;
        if (hresp == hresp_error && !first_err) begin
          report_failure("error response ended without its first low-ready cycle");
        end else if (hresp == hresp_okay && first_err) begin
          report_failure("first error cycle was not followed by a second error cycle");
        end
      end
    end
    if (!done) begin
      report_failure($sformatf("transfer at %h never completed, hreadyout stuck low", addr));
    end
  endtask

  `include "gpio_bridge_tests.svh"

  initial begin
    hsel      = 1'b0;
    haddr     = '0;
    hwdata    = '0;
    hwrite    = 1'b0;
    hsize     = hsize_byte;
    hburst    = 3'b000;  // single
    hprot     = 4'b0001;
    htrans    = htrans_idle;
    hmastlock = 1'b0;
    hready    = 1'b1;    // only slave on the bus
    gpio_in   = '0;
    HRESETn   = 1'b0;
    presetn   = 1'b0;
    repeat (16) @(posedge HCLK);
    HRESETn <= 1'b1;
    presetn <= 1'b1;
    repeat (4) @(posedge HCLK);
    verify_reset_state();
    byte_write_read();
    word_write_pin_readback();
    protection_errors();
    ignore_non_transfers();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, tests did not finish", watchdog_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
